/* common/issue_params.svh */
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// issue queue entries
`define IQ_DEPTH 8

// physical integer registers
`define PREG_NUM 64

// data path width
`define XLEN 32

// immediate field width, sign-extended on use
`define IMM_W 16

// age tag width, twice the queue depth
`define AGE_W 4

// multiplier cycles from capture to writeback
`define MUL_LAT 3

`endif

/* common/uop_pkg.sv */
`include "issue_params.svh"

package uop_pkg;

    typedef logic [$clog2(`PREG_NUM)-1:0] preg_t;
    typedef logic [`XLEN-1:0] xdata_t;
    typedef logic [`IMM_W-1:0] imm_t;

    // encodings are shared with the stimulus file
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_sll = 3'd5,
        op_mul = 3'd6
    } opcode_t;

    typedef enum logic {
        fu_alu = 1'b0,
        fu_mul = 1'b1
    } fu_kind_t;

    // unit kind that executes an opcode
    function automatic fu_kind_t fu_of(input opcode_t op);
        return (op == op_mul) ? fu_mul : fu_alu;
    endfunction

    function automatic xdata_t sext_imm(input imm_t imm);
        return {{(`XLEN - `IMM_W){imm[`IMM_W-1]}}, imm};
    endfunction

endpackage

/* common/sched_pkg.sv */
`include "issue_params.svh"

package sched_pkg;

    typedef logic [$clog2(`IQ_DEPTH)-1:0] iq_idx_t;
    typedef logic [`AGE_W-1:0] age_t;

    typedef enum logic [1:0] {
        st_free   = 2'd0,
        st_wait   = 2'd1,
        st_issued = 2'd2
    } entry_state_t;

    // a is older than b when a - b wraps negative
    // holds while fewer than half the tag space is live
    function automatic logic is_older(input age_t a, input age_t b);
        age_t diff;
        diff = a - b;
        return diff[`AGE_W-1];
    endfunction

endpackage

/* issue_queue/iq_entries.sv */
`timescale 1ns/10ps
`include "issue_params.svh"

module iq_entries (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_wr_en,
    input  sched_pkg::iq_idx_t   i_wr_idx,
    input  uop_pkg::opcode_t     i_wr_op,
    input  uop_pkg::preg_t       i_wr_prd,
    input  uop_pkg::preg_t       i_wr_prs1,
    input  uop_pkg::preg_t       i_wr_prs2,
    input  logic                 i_wr_use_imm,
    input  uop_pkg::imm_t        i_wr_imm,
    input  logic [1:0]           i_wr_src_rdy,
    input  logic [1:0]           i_wb_valid,
    input  uop_pkg::preg_t       i_wb_prd [2],
    output logic [1:0]           o_src_rdy_next [`IQ_DEPTH],
    output uop_pkg::fu_kind_t    o_fu_kind [`IQ_DEPTH],
    input  logic [1:0]           i_rd_valid,
    input  sched_pkg::iq_idx_t   i_rd_idx [2],
    input  uop_pkg::xdata_t      i_rf_rdata [4],
    output logic [1:0]           o_rd_valid,
    output uop_pkg::opcode_t     o_rd_op,
    output uop_pkg::preg_t       o_rd_prd [2],
    output uop_pkg::preg_t       o_rf_raddr [4],
    output uop_pkg::xdata_t      o_rd_opb [2]
);
    uop_pkg::opcode_t e_op [`IQ_DEPTH];
    uop_pkg::preg_t   e_prd [`IQ_DEPTH];
    uop_pkg::preg_t   e_prs1 [`IQ_DEPTH];
    uop_pkg::preg_t   e_prs2 [`IQ_DEPTH];
    logic             e_use_imm [`IQ_DEPTH];
    uop_pkg::imm_t    e_imm [`IQ_DEPTH];
    logic [1:0]       e_src_rdy [`IQ_DEPTH];

    logic [1:0]       rd_use_imm;
    uop_pkg::imm_t    rd_imm [2];

    // wakeup: match both writeback buses against every source
    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            o_src_rdy_next[i] = e_src_rdy[i];
            o_fu_kind[i] = uop_pkg::fu_of(e_op[i]);
            for (int w = 0; w < 2; w++) begin
                if (i_wb_valid[w] && e_prs1[i] == i_wb_prd[w]) begin
                    o_src_rdy_next[i][0] = 1'b1;
                end
                if (i_wb_valid[w] && e_prs2[i] == i_wb_prd[w]) begin
                    o_src_rdy_next[i][1] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            e_op[i_wr_idx] <= i_wr_op;
            e_prd[i_wr_idx] <= i_wr_prd;
            e_prs1[i_wr_idx] <= i_wr_prs1;
            e_prs2[i_wr_idx] <= i_wr_prs2;
            e_use_imm[i_wr_idx] <= i_wr_use_imm;
            e_imm[i_wr_idx] <= i_wr_imm;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                e_src_rdy[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                if (i_wr_en && i_wr_idx == sched_pkg::iq_idx_t'(i)) begin
                    e_src_rdy[i] <= i_wr_src_rdy;
                end else begin
                    e_src_rdy[i] <= o_src_rdy_next[i];
                end
            end
        end
    end

    // read stage registers, one cycle after grant
    always_ff @(posedge clk) begin
        if (rst) begin
            o_rd_valid <= '0;
        end else begin
            o_rd_valid <= i_rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        o_rd_op <= e_op[i_rd_idx[0]];
        for (int p = 0; p < 2; p++) begin
            o_rd_prd[p] <= e_prd[i_rd_idx[p]];
            o_rf_raddr[2*p] <= e_prs1[i_rd_idx[p]];
            o_rf_raddr[2*p+1] <= e_prs2[i_rd_idx[p]];
            rd_use_imm[p] <= e_use_imm[i_rd_idx[p]];
            rd_imm[p] <= e_imm[i_rd_idx[p]];
        end
    end

    // second operand: register or immediate
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            if (rd_use_imm[p]) begin
                o_rd_opb[p] = uop_pkg::sext_imm(rd_imm[p]);
            end else begin
                o_rd_opb[p] = i_rf_rdata[2*p+1];
            end
        end
    end

endmodule

/* issue_queue/age_select.sv */
`timescale 1ns/10ps
`include "issue_params.svh"

module age_select (
    input  logic [`IQ_DEPTH-1:0] i_req [2],
    input  sched_pkg::age_t      i_age [`IQ_DEPTH],
    output logic [1:0]           o_found,
    output sched_pkg::iq_idx_t   o_idx [2]
);
    logic [`IQ_DEPTH-1:0] oldest [2];

    // an entry wins when it is older than every other requester
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                oldest[p][i] = i_req[p][i];
                for (int j = 0; j < `IQ_DEPTH; j++) begin
                    if (j != i && i_req[p][j]
                            && !sched_pkg::is_older(i_age[i], i_age[j])) begin
                        oldest[p][i] = 1'b0;
                    end
                end
            end
        end
    end

    // tags are unique among live entries, so at most one bit is set
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            o_found[p] = |oldest[p];
            o_idx[p] = '0;
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                if (oldest[p][i]) begin
                    o_idx[p] = sched_pkg::iq_idx_t'(i);
                end
            end
        end
    end

endmodule

/* issue_queue/issue_ctrl.sv */
`timescale 1ns/10ps
`include "issue_params.svh"

module issue_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_enq_valid,
    input  uop_pkg::preg_t        i_enq_prd,
    input  uop_pkg::preg_t        i_enq_prs1,
    input  uop_pkg::preg_t        i_enq_prs2,
    input  logic                  i_enq_use_imm,
    output logic                  o_can_enq,
    output logic                  o_wr_en,
    output sched_pkg::iq_idx_t    o_wr_idx,
    output logic [1:0]            o_wr_src_rdy,
    input  logic [1:0]            i_src_rdy_next [`IQ_DEPTH],
    input  uop_pkg::fu_kind_t     i_fu_kind [`IQ_DEPTH],
    output logic [`IQ_DEPTH-1:0]  o_req [2],
    output sched_pkg::age_t       o_age [`IQ_DEPTH],
    input  logic [1:0]            i_found,
    input  sched_pkg::iq_idx_t    i_sel_idx [2],
    input  logic                  i_mul_busy,
    input  logic [1:0]            i_wb_valid,
    input  uop_pkg::preg_t        i_wb_prd [2],
    output logic [1:0]            o_iss_valid,
    output sched_pkg::iq_idx_t    o_iss_idx [2]
);
    sched_pkg::entry_state_t state [`IQ_DEPTH];
    sched_pkg::age_t         age_cnt;
    logic [`PREG_NUM-1:0]    rdy_tbl;
    logic [`PREG_NUM-1:0]    wb_hit;
    logic [`IQ_DEPTH-1:0]    entry_rdy;
    logic [1:0]              gnt;

    always_comb begin
        wb_hit = '0;
        for (int w = 0; w < 2; w++) begin
            if (i_wb_valid[w]) begin
                wb_hit[i_wb_prd[w]] = 1'b1;
            end
        end
    end

    // lowest numbered free entry takes the next op
    always_comb begin
        o_can_enq = 1'b0;
        o_wr_idx = '0;
        for (int i = `IQ_DEPTH - 1; i >= 0; i--) begin
            if (state[i] == sched_pkg::st_free) begin
                o_can_enq = 1'b1;
                o_wr_idx = sched_pkg::iq_idx_t'(i);
            end
        end
    end

    assign o_wr_en = i_enq_valid && o_can_enq;
    assign o_wr_src_rdy[0] = rdy_tbl[i_enq_prs1] || wb_hit[i_enq_prs1];
    assign o_wr_src_rdy[1] = i_enq_use_imm || rdy_tbl[i_enq_prs2] || wb_hit[i_enq_prs2];

    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            entry_rdy[i] = (state[i] == sched_pkg::st_wait) && (&i_src_rdy_next[i]);
            o_req[0][i] = entry_rdy[i] && (i_fu_kind[i] == uop_pkg::fu_alu);
            o_req[1][i] = entry_rdy[i] && (i_fu_kind[i] == uop_pkg::fu_mul);
        end
    end

    // multiplier is not pipelined, keep a gap after each grant
    assign gnt[0] = i_found[0];
    assign gnt[1] = i_found[1] && !i_mul_busy && !o_iss_valid[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                state[i] <= sched_pkg::st_free;
            end
            age_cnt <= '0;
            rdy_tbl <= '1;
            o_iss_valid <= '0;
        end else begin
            // release at read stage, then grant, then enqueue
            for (int p = 0; p < 2; p++) begin
                if (o_iss_valid[p]) begin
                    state[o_iss_idx[p]] <= sched_pkg::st_free;
                end
                if (gnt[p]) begin
                    state[i_sel_idx[p]] <= sched_pkg::st_issued;
                end
            end
            if (o_wr_en) begin
                state[o_wr_idx] <= sched_pkg::st_wait;
                age_cnt <= age_cnt + 1'b1;
            end
            rdy_tbl <= rdy_tbl | wb_hit;
            if (o_wr_en) begin
                rdy_tbl[i_enq_prd] <= 1'b0;
            end
            o_iss_valid <= gnt;
        end
    end

    always_ff @(posedge clk) begin
        o_iss_idx <= i_sel_idx;
        if (o_wr_en) begin
            o_age[o_wr_idx] <= age_cnt;
        end
    end

endmodule

/* logic/int_regfile.sv */
`timescale 1ns/10ps
`include "issue_params.svh"

module int_regfile (
    input  logic             clk,
    input  logic             rst,
    input  uop_pkg::preg_t   i_raddr [4],
    output uop_pkg::xdata_t  o_rdata [4],
    input  logic [1:0]       i_wen,
    input  uop_pkg::preg_t   i_waddr [2],
    input  uop_pkg::xdata_t  i_wdata [2]
);
    uop_pkg::xdata_t regs [`PREG_NUM];

    // two reads per issue port
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            o_rdata[k] = regs[i_raddr[k]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `PREG_NUM; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (i_wen[w]) begin
                    regs[i_waddr[w]] <= i_wdata[w];
                end
            end
        end
    end

endmodule

/* logic/int_alu.sv */
`timescale 1ns/10ps
`include "issue_params.svh"

module int_alu (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_valid,
    input  uop_pkg::opcode_t  i_op,
    input  uop_pkg::preg_t    i_prd,
    input  uop_pkg::xdata_t   i_a,
    input  uop_pkg::xdata_t   i_b,
    output logic              o_wb_valid,
    output uop_pkg::preg_t    o_wb_prd,
    output uop_pkg::xdata_t   o_wb_data
);
    uop_pkg::xdata_t result;

    always_comb begin
        case (i_op)
            uop_pkg::op_add: result = i_a + i_b;
            uop_pkg::op_sub: result = i_a - i_b;
            uop_pkg::op_and: result = i_a & i_b;
            uop_pkg::op_or:  result = i_a | i_b;
            uop_pkg::op_xor: result = i_a ^ i_b;
            // shift amount from the low bits only
            uop_pkg::op_sll: result = i_a << i_b[$clog2(`XLEN)-1:0];
            default:         result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_wb_valid <= 1'b0;
        end else begin
            o_wb_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        o_wb_prd <= i_prd;
        o_wb_data <= result;
    end

endmodule

/* logic/mul_unit.sv */
`timescale 1ns/10ps
`include "issue_params.svh"

module mul_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_valid,
    input  uop_pkg::preg_t   i_prd,
    input  uop_pkg::xdata_t  i_a,
    input  uop_pkg::xdata_t  i_b,
    output logic             o_busy,
    output logic             o_wb_valid,
    output uop_pkg::preg_t   o_wb_prd,
    output uop_pkg::xdata_t  o_wb_data
);
    localparam int CNT_W = $clog2(`MUL_LAT + 1);

    logic             busy_q;
    logic [CNT_W-1:0] cnt;
    uop_pkg::xdata_t  a_q;
    uop_pkg::xdata_t  b_q;
    uop_pkg::preg_t   prd_q;

    // an op in the read stage already claims the unit
    assign o_busy = busy_q || i_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            cnt <= '0;
            o_wb_valid <= 1'b0;
        end else begin
            o_wb_valid <= 1'b0;
            if (busy_q) begin
                cnt <= cnt - 1'b1;
                if (cnt == CNT_W'(1)) begin
                    busy_q <= 1'b0;
                    o_wb_valid <= 1'b1;
                end
            end else if (i_valid) begin
                busy_q <= 1'b1;
                cnt <= CNT_W'(`MUL_LAT);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid && !busy_q) begin
            a_q <= i_a;
            b_q <= i_b;
            prd_q <= i_prd;
        end
        // low half of the product
        if (busy_q && cnt == CNT_W'(1)) begin
            o_wb_prd <= prd_q;
            o_wb_data <= a_q * b_q;
        end
    end

endmodule

/* logic/issue_cluster_top.sv */
`timescale 1ns/10ps
`include "issue_params.svh"

module issue_cluster_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_enq_valid,
    input  uop_pkg::opcode_t  i_enq_op,
    input  uop_pkg::preg_t    i_enq_prd,
    input  uop_pkg::preg_t    i_enq_prs1,
    input  uop_pkg::preg_t    i_enq_prs2,
    input  logic              i_enq_use_imm,
    input  uop_pkg::imm_t     i_enq_imm,
    output logic              o_can_enq,
    output wire [1:0]         o_wb_valid,
    output uop_pkg::preg_t    o_wb_prd [2],
    output uop_pkg::xdata_t   o_wb_data [2]
);
    logic                  wr_en;
    sched_pkg::iq_idx_t    wr_idx;
    logic [1:0]            wr_src_rdy;
    logic [1:0]            src_rdy_next [`IQ_DEPTH];
    uop_pkg::fu_kind_t     fu_kind [`IQ_DEPTH];
    logic [`IQ_DEPTH-1:0]  req [2];
    sched_pkg::age_t       age [`IQ_DEPTH];
    logic [1:0]            found;
    sched_pkg::iq_idx_t    sel_idx [2];
    logic                  mul_busy;
    logic [1:0]            iss_valid;
    sched_pkg::iq_idx_t    iss_idx [2];
    logic [1:0]            rd_valid;
    uop_pkg::opcode_t      rd_op;
    uop_pkg::preg_t        rd_prd [2];
    uop_pkg::preg_t        rf_raddr [4];
    uop_pkg::xdata_t       rf_rdata [4];
    uop_pkg::xdata_t       opb [2];

    issue_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .i_enq_valid    (i_enq_valid),
        .i_enq_prd      (i_enq_prd),
        .i_enq_prs1     (i_enq_prs1),
        .i_enq_prs2     (i_enq_prs2),
        .i_enq_use_imm  (i_enq_use_imm),
        .o_can_enq      (o_can_enq),
        .o_wr_en        (wr_en),
        .o_wr_idx       (wr_idx),
        .o_wr_src_rdy   (wr_src_rdy),
        .i_src_rdy_next (src_rdy_next),
        .i_fu_kind      (fu_kind),
        .o_req          (req),
        .o_age          (age),
        .i_found        (found),
        .i_sel_idx      (sel_idx),
        .i_mul_busy     (mul_busy),
        .i_wb_valid     (o_wb_valid),
        .i_wb_prd       (o_wb_prd),
        .o_iss_valid    (iss_valid),
        .o_iss_idx      (iss_idx)
    );

    iq_entries u_entries (
        .clk            (clk),
        .rst            (rst),
        .i_wr_en        (wr_en),
        .i_wr_idx       (wr_idx),
        .i_wr_op        (i_enq_op),
        .i_wr_prd       (i_enq_prd),
        .i_wr_prs1      (i_enq_prs1),
        .i_wr_prs2      (i_enq_prs2),
        .i_wr_use_imm   (i_enq_use_imm),
        .i_wr_imm       (i_enq_imm),
        .i_wr_src_rdy   (wr_src_rdy),
        .i_wb_valid     (o_wb_valid),
        .i_wb_prd       (o_wb_prd),
        .o_src_rdy_next (src_rdy_next),
        .o_fu_kind      (fu_kind),
        .i_rd_valid     (iss_valid),
        .i_rd_idx       (iss_idx),
        .i_rf_rdata     (rf_rdata),
        .o_rd_valid     (rd_valid),
        .o_rd_op        (rd_op),
        .o_rd_prd       (rd_prd),
        .o_rf_raddr     (rf_raddr),
        .o_rd_opb       (opb)
    );

    age_select u_select (
        .i_req   (req),
        .i_age   (age),
        .o_found (found),
        .o_idx   (sel_idx)
    );

    int_regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .i_raddr (rf_raddr),
        .o_rdata (rf_rdata),
        .i_wen   (o_wb_valid),
        .i_waddr (o_wb_prd),
        .i_wdata (o_wb_data)
    );

    // port 0
    int_alu u_alu (
        .clk        (clk),
        .rst        (rst),
        .i_valid    (rd_valid[0]),
        .i_op       (rd_op),
        .i_prd      (rd_prd[0]),
        .i_a        (rf_rdata[0]),
        .i_b        (opb[0]),
        .o_wb_valid (o_wb_valid[0]),
        .o_wb_prd   (o_wb_prd[0]),
        .o_wb_data  (o_wb_data[0])
    );

    // port 1
    mul_unit u_mul (
        .clk        (clk),
        .rst        (rst),
        .i_valid    (rd_valid[1]),
        .i_prd      (rd_prd[1]),
        .i_a        (rf_rdata[2]),
        .i_b        (opb[1]),
        .o_busy     (mul_busy),
        .o_wb_valid (o_wb_valid[1]),
        .o_wb_prd   (o_wb_prd[1]),
        .o_wb_data  (o_wb_data[1])
    );

endmodule

/* sim/tb_issue_cluster.sv */
`timescale 1ns/10ps
`include "issue_params.svh"

module tb_issue_cluster;

    localparam int CLK_PERIOD = 20;
    localparam int MAX_LINES = 64;
    localparam int CYCLES_PER_LINE = 200;
    localparam int DRAIN_CYCLES = 10;
    // queue fill test streams its ops back to back
    localparam int FILL_TEST = 5;
    localparam int ORDER_TEST = 6;

    logic              clk;
    logic              rst;
    logic              enq_valid;
    uop_pkg::opcode_t  enq_op;
    uop_pkg::preg_t    enq_prd;
    uop_pkg::preg_t    enq_prs1;
    uop_pkg::preg_t    enq_prs2;
    logic              enq_use_imm;
    uop_pkg::imm_t     enq_imm;
    logic              can_enq;
    wire [1:0]         wb_valid;
    uop_pkg::preg_t    wb_prd [2];
    uop_pkg::xdata_t   wb_data [2];

    // stimulus lines, one op each
    int                t_num [MAX_LINES];
    int                t_op [MAX_LINES];
    int                t_prd [MAX_LINES];
    int                t_prs1 [MAX_LINES];
    int                t_prs2 [MAX_LINES];
    int                t_use_imm [MAX_LINES];
    logic [15:0]       t_imm [MAX_LINES];

    // expected register contents and writeback bookkeeping
    uop_pkg::xdata_t   exp_val [`PREG_NUM];
    logic              enq_seen [`PREG_NUM];
    int                wb_cnt [`PREG_NUM];
    int                wb_seq [`PREG_NUM];

    int                num_lines;
    int                errors;
    int                checks;
    int                tests_run;
    int                tests_failed;
    int                seq_ctr;
    logic              loaded;
    logic              saw_full;
    logic [15:0]       lfsr;

    issue_cluster_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .i_enq_valid   (enq_valid),
        .i_enq_op      (enq_op),
        .i_enq_prd     (enq_prd),
        .i_enq_prs1    (enq_prs1),
        .i_enq_prs2    (enq_prs2),
        .i_enq_use_imm (enq_use_imm),
        .i_enq_imm     (enq_imm),
        .o_can_enq     (can_enq),
        .o_wb_valid    (wb_valid),
        .o_wb_prd      (wb_prd),
        .o_wb_data     (wb_data)
    );

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // idle cycles before the next enqueue, 0 to 3
    task automatic draw_gap(output int gap);
        gap = 0;
        repeat (2) begin
            lfsr = lfsr_step(lfsr);
            gap = (gap << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic string test_name(input int t);
        case (t)
            2: return "independent immediate ops";
            3: return "dependent alu and mul chain";
            4: return "back-to-back multiplies";
            5: return "queue fill and retry";
            6: return "oldest ready first";
            default: return "unnamed";
        endcase
    endfunction

    task automatic load_stimulus();
        int fd;
        int n;
        int f_test;
        int f_op;
        int f_prd;
        int f_prs1;
        int f_prs2;
        int f_use;
        logic [15:0] f_imm;
        logic [31:0] f_exp;
        string line;
        fd = $fopen("sim/issue_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/issue_stimulus.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && num_lines < MAX_LINES) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "/") begin
                continue;
            end
            n = $sscanf(line, "%d %d %d %d %d %d %h %h", f_test, f_op, f_prd,
                        f_prs1, f_prs2, f_use, f_imm, f_exp);
            if (n != 8) begin
                $display("malformed stimulus line: %s", line);
                errors++;
            end else begin
                t_num[num_lines] = f_test;
                t_op[num_lines] = f_op;
                t_prd[num_lines] = f_prd;
                t_prs1[num_lines] = f_prs1;
                t_prs2[num_lines] = f_prs2;
                t_use_imm[num_lines] = f_use;
                t_imm[num_lines] = f_imm;
                exp_val[f_prd] = f_exp;
                num_lines++;
            end
        end
        $fclose(fd);
        if (num_lines == 0) begin
            $display("the stimulus file holds no ops");
            errors++;
        end
        loaded = 1'b1;
    endtask

    // holds the strobe until the queue has room
    task automatic enqueue_op(input int k);
        logic accepted;
        accepted = 1'b0;
        enq_valid = 1'b1;
        enq_op = uop_pkg::opcode_t'(t_op[k]);
        enq_prd = uop_pkg::preg_t'(t_prd[k]);
        enq_prs1 = uop_pkg::preg_t'(t_prs1[k]);
        enq_prs2 = uop_pkg::preg_t'(t_prs2[k]);
        enq_use_imm = (t_use_imm[k] != 0);
        enq_imm = t_imm[k];
        while (!accepted) begin
            // o_can_enq only moves on the rising edge
            if (can_enq) begin
                accepted = 1'b1;
                enq_seen[t_prd[k]] = 1'b1;
            end else begin
                saw_full = 1'b1;
            end
            @(negedge clk);
        end
        enq_valid = 1'b0;
    endtask

    function automatic int missing_count(input int first, input int last);
        int n;
        n = 0;
        for (int k = first; k <= last; k++) begin
            if (wb_cnt[t_prd[k]] == 0) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic report_test(input int t, input int errs_before, input string name);
        tests_run++;
        if (errors > errs_before) begin
            tests_failed++;
            $display("test %0d (%s): fail", t, name);
        end else begin
            $display("test %0d (%s): ok", t, name);
        end
    endtask

    task automatic check_reset_state();
        int errs_before;
        errs_before = errors;
        check_value("o_can_enq", 32'(can_enq), 32'd1);
        repeat (5) begin
            check_value("o_wb_valid", 32'(wb_valid), 32'd0);
            @(negedge clk);
        end
        report_test(1, errs_before, "reset state");
    endtask

    task automatic run_test(input int first, input int last);
        int errs_before;
        int gap;
        int prev_seq;
        int tnum;
        tnum = t_num[first];
        errs_before = errors;
        saw_full = 1'b0;
        for (int k = first; k <= last; k++) begin
            enqueue_op(k);
            if (tnum != FILL_TEST && k < last) begin
                draw_gap(gap);
                repeat (gap) @(negedge clk);
            end
        end
        while (missing_count(first, last) > 0) begin
            @(negedge clk);
        end
        // late duplicates would show up here
        repeat (DRAIN_CYCLES) @(negedge clk);
        for (int k = first; k <= last; k++) begin
            if (wb_cnt[t_prd[k]] != 1) begin
                $display("register p%0d was written back %0d times instead of once",
                         t_prd[k], wb_cnt[t_prd[k]]);
                errors++;
            end
        end
        if (tnum == FILL_TEST && !saw_full) begin
            $display("o_can_enq never fell while the queue was being filled");
            errors++;
        end
        if (tnum == ORDER_TEST) begin
            prev_seq = -1;
            for (int k = first; k <= last; k++) begin
                if (t_op[k] != int'(uop_pkg::op_mul)) begin
                    if (wb_seq[t_prd[k]] < prev_seq) begin
                        $display("younger op p%0d wrote back before an older ready op",
                                 t_prd[k]);
                        errors++;
                    end
                    prev_seq = wb_seq[t_prd[k]];
                end
            end
        end
        report_test(tnum, errs_before, test_name(tnum));
    endtask

    // writebacks are one-cycle pulses, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            for (int p = 0; p < 2; p++) begin
                if (wb_valid[p]) begin
                    if (!enq_seen[wb_prd[p]]) begin
                        $display("port %0d wrote back p%0d, which no enqueued op targets",
                                 p, wb_prd[p]);
                        errors++;
                    end else begin
                        check_value($sformatf("o_wb_data[%0d] (p%0d)", p, wb_prd[p]),
                                    wb_data[p], exp_val[wb_prd[p]]);
                    end
                    wb_cnt[wb_prd[p]]++;
                    wb_seq[wb_prd[p]] = seq_ctr;
                    seq_ctr++;
                end
            end
        end
    end

    initial begin
        wait (loaded === 1'b1);
        #(num_lines * CYCLES_PER_LINE * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles",
                 num_lines * CYCLES_PER_LINE);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int first;
        int last;
        rst = 1'b1;
        enq_valid = 1'b0;
        enq_op = uop_pkg::op_add;
        enq_prd = '0;
        enq_prs1 = '0;
        enq_prs2 = '0;
        enq_use_imm = 1'b0;
        enq_imm = '0;
        loaded = 1'b0;
        saw_full = 1'b0;
        num_lines = 0;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        seq_ctr = 0;
        lfsr = 16'd27401;
        for (int r = 0; r < `PREG_NUM; r++) begin
            exp_val[r] = '0;
            enq_seen[r] = 1'b0;
            wb_cnt[r] = 0;
            wb_seq[r] = 0;
        end
        load_stimulus();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (loaded) begin
            check_reset_state();
            first = 0;
            while (first < num_lines) begin
                last = first;
                while (last + 1 < num_lines && t_num[last + 1] == t_num[first]) begin
                    last++;
                end
                run_test(first, last);
                first = last + 1;
            end
        end
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sim/issue_stimulus.txt */
// test op prd prs1 prs2 use_imm imm(hex) expected(hex)
// op: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 sll, 6 mul
2 0 1 0 0 1 1234 00001234
2 1 2 0 0 1 0005 fffffffb
2 4 3 0 0 1 8001 ffff8001
3 5 4 1 0 1 0004 00012340
3 6 5 4 2 0 0000 fffa4fc0
3 2 6 5 3 0 0000 fffa0000
3 1 7 6 4 0 0000 fff8dcc0
4 6 8 1 1 0 0000 014b5a90
4 6 9 2 2 0 0000 00000019
4 6 10 4 0 1 0003 000369c0
5 6 11 2 0 1 fffd 0000000f
5 6 12 11 11 0 0000 000000e1
5 0 13 12 0 1 0001 000000e2
5 1 14 12 1 0 0000 ffffeead
5 2 15 12 0 1 00f0 000000e0
5 3 16 12 1 0 0000 000012f5
5 4 17 12 0 1 00ff 0000001e
5 5 18 12 0 1 0008 0000e100
5 6 19 12 0 1 0002 000001c2
5 0 20 12 12 0 0000 000001c2
5 5 21 1 12 0 0000 00002468
6 6 22 9 0 1 0007 000000af
6 6 23 22 0 1 0010 00000af0
6 0 24 23 0 1 0001 00000af1
6 4 25 23 1 0 0000 000018c4

/* compile.f */
+incdir+common
common/uop_pkg.sv
common/sched_pkg.sv
issue_queue/iq_entries.sv
issue_queue/age_select.sv
issue_queue/issue_ctrl.sv
logic/int_regfile.sv
logic/int_alu.sv
logic/mul_unit.sv
logic/issue_cluster_top.sv
sim/tb_issue_cluster.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f compile.f \
		--top-module tb_issue_cluster -Mdir obj_dir
	./obj_dir/Vtb_issue_cluster | tee $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
